// File: compile.f
+incdir+include
verilog/shader_pkg.sv
verilog/shade_req_if.sv
verilog/ray_id_freelist.sv
verilog/pixel_id_ram.sv
verilog/result_arbiter.sv
verilog/shade_pipe.sv
verilog/simple_shader_unit.sv
dv/shader_tb.sv

// File: dv/shader_tb.sv
`default_nettype none

`include "shader_colors.svh"

module shader_tb import shader_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_RAYS   = 16;
  localparam int OUT_DEPTH  = 4;
  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DLY  = 10;

  // test lengths in cycles
  localparam int T_INIT     = 60;
  localparam int T_RECYCLE  = 40;
  localparam int T_RANDOM   = 600;
  localparam int T_BURST    = 400;
  localparam int T_FAIR     = 200;
  localparam int T_DRAIN    = 300;
  localparam int RUN_CYCLES = 3 + T_INIT + T_RECYCLE + T_RANDOM + T_BURST + T_FAIR + T_DRAIN;
  localparam int WATCHDOG_NS = RUN_CYCLES * CLK_PERIOD * 12 / 10;

  localparam color_t PALETTE [4] = '{`TRI_COLOR_0, `TRI_COLOR_1, `TRI_COLOR_2, `TRI_COLOR_3};

  logic      clk;
  logic      arst_n;
  logic      prg_valid;
  pixel_id_t prg_pixel_id;
  ray_vec_t  prg_ray_vec;
  logic      prg_stall;
  // result sources: 0 pcalc, 1 int, 2 sint return, 3 ss
  logic [3:0] src_valid;
  ray_id_t    src_id [4];
  wire  [3:0] src_stall;
  tri_id_t    pcalc_tri_id;
  logic      sint_valid;
  ray_id_t   sint_ray_id;
  ray_vec_t  sint_ray_vec;
  logic      sint_stall;
  logic      pb_we;
  pb_entry_t pb_data;
  logic      pb_full;

  // stimulus knobs, rates are out of 256
  logic [31:0] rng_state = 32'd21;
  bit          issue_en = 1'b1;
  int          prg_rate = 256;
  int          sint_stall_rate = 0;
  int          ret_rate = 0;
  int          pb_rate = 0;
  int          pb_burst = 0;
  int          burst_left = 0;

  // scoreboard state
  logic       prg_taken = 1'b0;
  logic [3:0] src_taken = '0;
  ray_id_t    pend_q [$];
  pb_entry_t  exp_q [$];
  bit         out_busy [2**RAY_ID_W];
  pixel_id_t  out_pix [2**RAY_ID_W];
  int         wait_cnt [4] = '{default: 0};
  int cycle_cnt = 0;
  int issue_cnt = 0;
  int ret_cnt = 0;
  int pb_cnt = 0;
  int out_cnt = 0;
  int fair_hits = 0;
  int checks = 0;
  int errors = 0;
  int test_err_base = 0;

  simple_shader_unit #(.NUM_RAYS(NUM_RAYS), .OUT_DEPTH(OUT_DEPTH)) DUT (
    .clk, .arst_n,
    .prg_valid, .prg_pixel_id, .prg_ray_vec, .prg_stall,
    .pcalc_valid(src_valid[0]), .pcalc_ray_id(src_id[0]), .pcalc_tri_id,
    .pcalc_stall(src_stall[0]),
    .int_valid(src_valid[1]), .int_ray_id(src_id[1]), .int_stall(src_stall[1]),
    .sint_ret_valid(src_valid[2]), .sint_ret_ray_id(src_id[2]),
    .sint_ret_stall(src_stall[2]),
    .ss_valid(src_valid[3]), .ss_ray_id(src_id[3]), .ss_stall(src_stall[3]),
    .sint_valid, .sint_ray_id, .sint_ray_vec, .sint_stall,
    .pb_we, .pb_data, .pb_full
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic bit chance(input int rate);
    logic [31:0] r;
    r = next_random();
    return int'(r[7:0]) < rate;
  endfunction

  // colour a returned ray should get, from the source that returned it
  function automatic color_t expected_color(input int src, input tri_id_t tri_id);
    if (src == 0) return PALETTE[tri_id[1:0]];
    if (src == 1) return `FLAT_HIT_COLOR;
    return `MISS_COLOR;
  endfunction

  function automatic bit is_idle();
    return !prg_valid && src_valid == '0 && pend_q.size() == 0 &&
           exp_q.size() == 0 && out_cnt == 0;
  endfunction

  task automatic report_mismatch(input string name, input string got, input string exp);
    errors++;
    $display("FAIL t=%0t %s got %s expected %s", $time, name, got, exp);
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("ERROR t=%0t %s", $time, what);
  endtask

  task automatic finish_test(input string name);
    $display("test %s: %s, %0d errors", name,
             (errors == test_err_base) ? "ok" : "failed", errors - test_err_base);
    test_err_base = errors;
  endtask

  // --------------------------------------------------------------------
  // driver, runs just after each rising edge
  // --------------------------------------------------------------------
  task automatic drive_inputs();
    logic [31:0] r;
    int          idx;
    // a prg ray holds until it is taken
    if (!prg_valid || prg_taken) begin
      r = next_random();
      prg_valid    = issue_en && (int'(r[7:0]) < prg_rate);
      prg_pixel_id = {r[18:10], 10'(issue_cnt)};
      prg_ray_vec  = {next_random(), next_random(), next_random()};
    end
    sint_stall = chance(sint_stall_rate);
    if (burst_left > 0) begin
      burst_left--;
    end else begin
      pb_full = chance(pb_rate);
      if (pb_full) burst_left = pb_burst;
    end
    // return outstanding ids through whichever source is free
    for (int i = 0; i < 4; i++) begin
      if (src_taken[i]) src_valid[i] = 1'b0;
      if (!src_valid[i] && pend_q.size() > 0 && chance(ret_rate)) begin
        r = next_random();
        idx = int'(r[15:0]) % pend_q.size();
        src_id[i] = pend_q[idx];
        pend_q.delete(idx);
        src_valid[i] = 1'b1;
        if (i == 0) pcalc_tri_id = r[31:16];
      end
    end
  endtask

  always begin
    @(posedge clk);
    #(DRIVE_DLY);
    drive_inputs();
  end

  // --------------------------------------------------------------------
  // monitor, samples mid-cycle what the next edge will transfer
  // --------------------------------------------------------------------
  task automatic match_write(input pb_entry_t e);
    int idx;
    idx = -1;
    checks++;
    foreach (exp_q[k]) begin
      if (idx < 0 && exp_q[k].pixel_id == e.pixel_id) idx = k;
    end
    if (idx < 0) begin
      report_error($sformatf("pixel write for pixel %h matches no returned ray", e.pixel_id));
    end else begin
      if (exp_q[idx].color != e.color) begin
        report_mismatch("pb_data.color", $sformatf("%h", e.color),
                        $sformatf("%h", exp_q[idx].color));
      end
      exp_q.delete(idx);
    end
  endtask

  task automatic sample_cycle();
    logic      fire;
    logic      exp_valid;
    logic      exp_fire;
    int        n_taken;
    pb_entry_t e;
    cycle_cnt++;
    fire      = prg_valid && !prg_stall;
    exp_valid = prg_valid && (cycle_cnt > NUM_RAYS) && (out_cnt < NUM_RAYS);
    exp_fire  = exp_valid && !sint_stall;
    checks++;
    if (fire !== exp_fire) begin
      report_mismatch("prg transfer", $sformatf("%b", fire), $sformatf("%b", exp_fire));
    end
    checks++;
    if (sint_valid !== exp_valid) begin
      report_mismatch("sint_valid", $sformatf("%b", sint_valid), $sformatf("%b", exp_valid));
    end
    if (fire) begin
      checks++;
      if (out_busy[sint_ray_id]) begin
        report_error($sformatf("ray id %0d issued again while outstanding", sint_ray_id));
      end
      if (issue_cnt < NUM_RAYS && sint_ray_id != ray_id_t'(issue_cnt)) begin
        report_mismatch("sint_ray_id", $sformatf("%0d", sint_ray_id),
                        $sformatf("%0d", issue_cnt));
      end
      out_busy[sint_ray_id] = 1'b1;
      out_pix[sint_ray_id]  = prg_pixel_id;
      pend_q.push_back(sint_ray_id);
      out_cnt++;
      issue_cnt++;
    end
    prg_taken = fire;
    src_taken = src_valid & ~src_stall;
    n_taken   = $countones(src_taken);
    if (n_taken > 1) report_error("more than one result source transferred in one cycle");
    if (&src_valid) fair_hits++;
    for (int i = 0; i < 4; i++) begin
      if (src_taken[i]) begin
        e.color    = expected_color(i, pcalc_tri_id);
        e.pixel_id = out_pix[src_id[i]];
        exp_q.push_back(e);
        out_busy[src_id[i]] = 1'b0;
        out_cnt--;
        ret_cnt++;
        wait_cnt[i] = 0;
      end else if (src_valid[i] && n_taken > 0) begin
        wait_cnt[i]++;
        checks++;
        if (wait_cnt[i] > 3) begin
          report_error($sformatf("source %0d saw %0d other transfers before its own",
                                 i, wait_cnt[i]));
        end
      end else if (!src_valid[i]) begin
        wait_cnt[i] = 0;
      end
    end
    if (pb_we) begin
      pb_cnt++;
      match_write(pb_data);
    end
  endtask

  always @(negedge clk) begin
    if (arst_n) begin
      sample_cycle();
    end else begin
      prg_taken = 1'b0;
      src_taken = '0;
    end
  end

  a_pb_full: assert property (@(posedge clk) disable iff (!arst_n) !(pb_we && pb_full))
    else report_error("pb_we was high while pb_full was high");

  a_stall_pass: assert property (@(posedge clk) disable iff (!arst_n) sint_stall |-> prg_stall)
    else report_error("prg_stall was low while sint_stall was high");

  a_vec_pass: assert property (@(posedge clk) disable iff (!arst_n)
    sint_valid |-> (sint_ray_vec == prg_ray_vec))
    else report_mismatch("sint_ray_vec", $sformatf("%h", $sampled(sint_ray_vec)),
                         $sformatf("%h", $sampled(prg_ray_vec)));

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("Simulation FAILED");
    $finish;
  end

  // --------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------
  initial begin
    int n;
    arst_n       = 1'b0;
    prg_valid    = 1'b0;
    prg_pixel_id = '0;
    prg_ray_vec  = '0;
    src_valid    = '0;
    src_id       = '{default: '0};
    pcalc_tri_id = '0;
    sint_stall   = 1'b0;
    pb_full      = 1'b0;
    repeat (3) @(posedge clk);
    #(DRIVE_DLY);
    arst_n = 1'b1;

    // free list fills, then ids 0..15 leave in order
    n = 0;
    while (issue_cnt < NUM_RAYS && n < T_INIT) begin
      @(posedge clk);
      n++;
    end
    checks++;
    if (issue_cnt < NUM_RAYS) report_error("the first 16 ray ids were not issued in time");
    finish_test("init");

    // every id out, prg must wait for a return
    repeat (10) @(posedge clk);
    checks++;
    if (issue_cnt != NUM_RAYS) report_error("a ray was issued with no free ray id");
    ret_rate = 256;
    n = 10;
    while (issue_cnt <= NUM_RAYS && n < T_RECYCLE) begin
      @(posedge clk);
      n++;
    end
    checks++;
    if (issue_cnt <= NUM_RAYS) report_error("no ray was issued after ids were returned");
    finish_test("recycle");

    prg_rate        = 180;
    sint_stall_rate = 60;
    ret_rate        = 100;
    pb_rate         = 50;
    repeat (T_RANDOM) @(posedge clk);
    finish_test("random");

    // long pb_full stretches
    prg_rate        = 200;
    sint_stall_rate = 30;
    ret_rate        = 150;
    pb_rate         = 20;
    pb_burst        = 30;
    repeat (T_BURST) @(posedge clk);
    finish_test("pb_burst");

    pb_rate         = 0;
    pb_burst        = 0;
    sint_stall_rate = 0;
    prg_rate        = 256;
    ret_rate        = 256;
    fair_hits       = 0;
    repeat (T_FAIR) @(posedge clk);
    checks++;
    if (fair_hits == 0) report_error("all four result sources never held valid together");
    finish_test("fairness");

    issue_en = 1'b0;
    n = 0;
    while (!is_idle() && n < T_DRAIN) begin
      @(posedge clk);
      n++;
    end
    checks++;
    if (!is_idle()) report_error("rays or pixel writes still pending after the drain");
    if (ret_cnt != issue_cnt) report_mismatch("returned count", $sformatf("%0d", ret_cnt),
                                              $sformatf("%0d", issue_cnt));
    if (pb_cnt != ret_cnt) report_mismatch("pb write count", $sformatf("%0d", pb_cnt),
                                           $sformatf("%0d", ret_cnt));
    finish_test("drain");

    $display("summary: %0d checks, %0d errors, %0d issued, %0d returned, %0d pixel writes",
             checks, errors, issue_cnt, ret_cnt, pb_cnt);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: include/shader_colors.svh
`ifndef SHADER_COLORS_SVH
`define SHADER_COLORS_SVH

// background seen by rays that leave the scene
`define MISS_COLOR      24'h10_18_40

// hit reported without a triangle id
`define FLAT_HIT_COLOR  24'h80_80_80

// triangle palette, picked by the two low bits of the triangle id
`define TRI_COLOR_0     24'hff_30_30
`define TRI_COLOR_1     24'h30_ff_30
`define TRI_COLOR_2     24'h30_30_ff
`define TRI_COLOR_3     24'hff_e0_20

`endif

// File: run.sh
#!/bin/sh
# build and run the shader testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f compile.f \
  --top-module shader_tb \
  -o shader_tb_sim

status=0
./obj_dir/shader_tb_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log || [ "$status" -ne 0 ]; then
  echo "run failed, see sim.log"
  exit 1
fi
echo "run passed"

// File: verilog/pixel_id_ram.sv
`default_nettype none

module pixel_id_ram import shader_pkg::*; #(
  parameter int NUM_RAYS = 512
) (
  input  logic      clk,
  input  logic      we,
  input  ray_id_t   waddr,
  input  pixel_id_t wdata,
  input  ray_id_t   raddr,
  output pixel_id_t rdata
);

  localparam int AW = (NUM_RAYS > 1) ? $clog2(NUM_RAYS) : 1;

  pixel_id_t mem [NUM_RAYS];

  // ids never exceed NUM_RAYS-1, so the low bits index the array
  logic [AW-1:0] wa;
  logic [AW-1:0] ra;

  assign wa = waddr[AW-1:0];
  assign ra = raddr[AW-1:0];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wa] <= wdata;
    end
  end

  // registered read, one cycle
  always_ff @(posedge clk) begin
    rdata <= mem[ra];
  end

endmodule

`default_nettype wire

// File: verilog/ray_id_freelist.sv
`default_nettype none

module ray_id_freelist import shader_pkg::*; #(
  parameter int NUM_RAYS = 512
) (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    pop,
  input  logic    push,
  input  ray_id_t push_id,
  output ray_id_t head_id,
  output logic    empty,
  output logic    init_done
);

  localparam int PTR_W = (NUM_RAYS > 1) ? $clog2(NUM_RAYS) : 1;
  localparam int CNT_W = $clog2(NUM_RAYS + 1);

  ray_id_t          ids [NUM_RAYS];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             wr_en;
  logic             rd_en;
  ray_id_t          wr_id;

  // ------------------------------------------------------------------
  // write source: counter while filling, returned ids afterwards
  // ------------------------------------------------------------------
  assign wr_en = init_done ? push : 1'b1;
  assign wr_id = init_done ? push_id : ray_id_t'(count);
  assign rd_en = pop & ~empty;

  // nothing leaves until every id has been loaded
  assign empty   = ~init_done | (count == '0);
  assign full    = (count == CNT_W'(NUM_RAYS));
  assign head_id = ids[rd_ptr];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr    <= '0;
      wr_ptr    <= '0;
      count     <= '0;
      init_done <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(NUM_RAYS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(NUM_RAYS - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
      // last init write lands this cycle
      if (!init_done && count == CNT_W'(NUM_RAYS - 1)) begin
        init_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      ids[wr_ptr] <= wr_id;
    end
  end

  // ------------------------------------------------------------------
  // checks
  // ------------------------------------------------------------------
  // the prg path must honour the empty flag it is given
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
    pop |-> !empty);

  // a returned id is always one that was issued earlier
  a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
    push |-> (init_done && !full));

endmodule

`default_nettype wire

// File: verilog/result_arbiter.sv
`default_nettype none

// source index: 0 pcalc, 1 int, 2 sint, 3 ss
module result_arbiter import shader_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic [3:0]      src_valid,
  input  ray_id_t [3:0]   src_ray_id,
  input  tri_id_t         pcalc_tri_id,
  output logic [3:0]      src_stall,
  shade_req_if.arb        req
);

  logic [1:0] last_win;
  logic [1:0] win_idx;
  logic [3:0] grant;
  logic       xfer;

  // ------------------------------------------------------------------
  // round-robin pick, search starts just past the last winner
  // ------------------------------------------------------------------
  always_comb begin
    logic [1:0] cand;
    logic       found;
    grant   = '0;
    win_idx = last_win;
    found   = 1'b0;
    for (int i = 1; i <= 4; i++) begin
      cand = last_win + 2'(i);
      if (!found && src_valid[cand]) begin
        found         = 1'b1;
        win_idx       = cand;
        grant[cand]   = 1'b1;
      end
    end
  end

  assign req.valid   = |grant;
  assign req.ray_id  = src_ray_id[win_idx];
  // pcalc and int are hits, only pcalc names a triangle
  assign req.is_hit  = ~win_idx[1];
  assign req.has_tri = (win_idx == 2'd0);
  assign req.tri_id  = (win_idx == 2'd0) ? pcalc_tri_id : '0;

  assign xfer = req.valid & ~req.stall;

  // only the winner moves, and only when the pipe takes it
  assign src_stall = ~grant | {4{req.stall}};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // source 0 gets first pick after reset
      last_win <= 2'd3;
    end else if (xfer) begin
      last_win <= win_idx;
    end
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0(grant));

endmodule

`default_nettype wire

// File: verilog/shade_pipe.sv
`default_nettype none

module shade_pipe import shader_pkg::*; #(
  parameter int OUT_DEPTH = 4
) (
  input  logic       clk,
  input  logic       arst_n,
  shade_req_if.pipe  req,
  output ray_id_t    ram_raddr,
  input  pixel_id_t  ram_rdata,
  input  logic       pb_full,
  output logic       pb_we,
  output pb_entry_t  pb_data
);

  localparam int PTR_W = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
  localparam int CNT_W = $clog2(OUT_DEPTH + 1);

  logic      req_fire;

  logic      stg_valid;
  tri_id_t   stg_tri_id;
  logic      stg_is_hit;
  logic      stg_has_tri;

  pb_entry_t        fifo_mem [OUT_DEPTH];
  pb_entry_t        fifo_wdata;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] fifo_cnt;
  logic             fifo_we;
  logic             fifo_re;
  logic             fifo_full;
  logic             fifo_empty;

  assign req_fire  = req.valid & ~req.stall;
  // ram lookup goes out in the transfer cycle
  assign ram_raddr = req.ray_id;

  // ------------------------------------------------------------------
  // stage register, waits one cycle for the ram data
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stg_valid <= 1'b0;
    end else begin
      stg_valid <= req_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      stg_tri_id  <= req.tri_id;
      stg_is_hit  <= req.is_hit;
      stg_has_tri <= req.has_tri;
    end
  end

  always_comb begin
    fifo_wdata.color    = calc_color(stg_is_hit, stg_has_tri, stg_tri_id);
    fifo_wdata.pixel_id = ram_rdata;
  end

  // ------------------------------------------------------------------
  // output FIFO toward the pixel buffer
  // ------------------------------------------------------------------
  assign fifo_we    = stg_valid;
  assign fifo_re    = pb_we;
  assign fifo_empty = (fifo_cnt == '0);
  assign fifo_full  = (fifo_cnt == CNT_W'(OUT_DEPTH));

  assign pb_we   = ~fifo_empty & ~pb_full;
  assign pb_data = fifo_mem[rd_ptr];

  // credit: the staged entry already owns a slot
  assign req.stall = (int'(fifo_cnt) + int'(stg_valid)) >= OUT_DEPTH;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr   <= '0;
      wr_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (fifo_we) begin
        wr_ptr <= (wr_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (fifo_re) begin
        rd_ptr <= (rd_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      fifo_cnt <= fifo_cnt + CNT_W'(fifo_we) - CNT_W'(fifo_re);
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_we) begin
      fifo_mem[wr_ptr] <= fifo_wdata;
    end
  end

  // the credit taken two cycles back must still hold here
  a_no_write_full: assert property (@(posedge clk) disable iff (!arst_n)
    fifo_we |-> !fifo_full);

endmodule

`default_nettype wire

// File: verilog/shade_req_if.sv
`default_nettype none

// one arbitrated ray result on its way into the shading pipe
interface shade_req_if import shader_pkg::*; ();

  logic    valid;
  logic    stall;
  ray_id_t ray_id;
  tri_id_t tri_id;
  logic    is_hit;
  logic    has_tri;

  // arbiter side drives the result
  modport arb (output valid, ray_id, tri_id, is_hit, has_tri, input stall);

  // pipe side consumes it and pushes back
  modport pipe (input valid, ray_id, tri_id, is_hit, has_tri, output stall);

endinterface

`default_nettype wire

// File: verilog/shader_pkg.sv
`default_nettype none

package shader_pkg;

  `include "shader_colors.svh"

  // ------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------
  // ray id width covers the largest free list, smaller lists use fewer ids
  localparam int RAY_ID_W   = 9;
  localparam int PIXEL_ID_W = 19;
  localparam int TRI_ID_W   = 16;
  localparam int COLOR_W    = 24;
  localparam int COORD_W    = 16;

  typedef logic [RAY_ID_W-1:0]   ray_id_t;
  typedef logic [PIXEL_ID_W-1:0] pixel_id_t;
  typedef logic [TRI_ID_W-1:0]   tri_id_t;
  typedef logic [COLOR_W-1:0]    color_t;

  // one 3-component vector
  typedef struct packed {
    logic [COORD_W-1:0] x;
    logic [COORD_W-1:0] y;
    logic [COORD_W-1:0] z;
  } vec3_t;

  typedef struct packed {
    vec3_t origin;
    vec3_t dir;
  } ray_vec_t;

  // pixel-buffer write entry
  typedef struct packed {
    color_t    color;
    pixel_id_t pixel_id;
  } pb_entry_t;

  // ------------------------------------------------------------------
  // colour of one returned ray
  // ------------------------------------------------------------------
  function automatic color_t calc_color(input logic    is_hit,
                                        input logic    has_tri,
                                        input tri_id_t tri_id);
    color_t c;
    if (!is_hit) begin
      c = `MISS_COLOR;
    end else if (!has_tri) begin
      c = `FLAT_HIT_COLOR;
    end else begin
      case (tri_id[1:0])
        2'd0:    c = `TRI_COLOR_0;
        2'd1:    c = `TRI_COLOR_1;
        2'd2:    c = `TRI_COLOR_2;
        default: c = `TRI_COLOR_3;
      endcase
    end
    return c;
  endfunction

endpackage

`default_nettype wire

// File: verilog/simple_shader_unit.sv
`default_nettype none

module simple_shader_unit import shader_pkg::*; #(
  parameter int NUM_RAYS  = 512,
  parameter int OUT_DEPTH = 4
) (
  input  logic      clk,
  input  logic      arst_n,

  // primary rays in
  input  logic      prg_valid,
  input  pixel_id_t prg_pixel_id,
  input  ray_vec_t  prg_ray_vec,
  output logic      prg_stall,

  // returned results
  input  logic      pcalc_valid,
  input  ray_id_t   pcalc_ray_id,
  input  tri_id_t   pcalc_tri_id,
  output logic      pcalc_stall,
  input  logic      int_valid,
  input  ray_id_t   int_ray_id,
  output logic      int_stall,
  input  logic      sint_ret_valid,
  input  ray_id_t   sint_ret_ray_id,
  output logic      sint_ret_stall,
  input  logic      ss_valid,
  input  ray_id_t   ss_ray_id,
  output logic      ss_stall,

  // rays out to scene intersection
  output logic      sint_valid,
  output ray_id_t   sint_ray_id,
  output ray_vec_t  sint_ray_vec,
  input  logic      sint_stall,

  // pixel buffer
  output logic      pb_we,
  output pb_entry_t pb_data,
  input  logic      pb_full
);

  logic          fl_empty;
  ray_id_t       fl_head_id;
  logic          prg_fire;
  logic          ret_fire;
  ray_id_t       ram_raddr;
  pixel_id_t     ram_rdata;
  logic [3:0]    arb_valid;
  logic [3:0]    arb_stall;
  ray_id_t [3:0] arb_ray_id;

  shade_req_if req_bus ();

  // ------------------------------------------------------------------
  // prg -> sint, combinational
  // ------------------------------------------------------------------
  assign prg_stall    = sint_stall | fl_empty;
  assign sint_valid   = prg_valid & ~fl_empty;
  assign sint_ray_id  = fl_head_id;
  assign sint_ray_vec = prg_ray_vec;
  assign prg_fire     = prg_valid & ~prg_stall;

  // a finished result hands its id back
  assign ret_fire = req_bus.valid & ~req_bus.stall;

  ray_id_freelist #(.NUM_RAYS(NUM_RAYS)) u_freelist (
    .clk, .arst_n,
    .pop(prg_fire), .push(ret_fire), .push_id(req_bus.ray_id),
    .head_id(fl_head_id), .empty(fl_empty), .init_done()
  );

  pixel_id_ram #(.NUM_RAYS(NUM_RAYS)) u_pixel_ram (
    .clk,
    .we(prg_fire), .waddr(fl_head_id), .wdata(prg_pixel_id),
    .raddr(ram_raddr), .rdata(ram_rdata)
  );

  // ------------------------------------------------------------------
  // result sources
  // ------------------------------------------------------------------
  assign arb_valid = {ss_valid, sint_ret_valid, int_valid, pcalc_valid};
  always_comb begin
    arb_ray_id[0] = pcalc_ray_id;
    arb_ray_id[1] = int_ray_id;
    arb_ray_id[2] = sint_ret_ray_id;
    arb_ray_id[3] = ss_ray_id;
  end
  assign pcalc_stall    = arb_stall[0];
  assign int_stall      = arb_stall[1];
  assign sint_ret_stall = arb_stall[2];
  assign ss_stall       = arb_stall[3];

  result_arbiter u_arbiter (
    .clk, .arst_n,
    .src_valid(arb_valid), .src_ray_id(arb_ray_id),
    .pcalc_tri_id, .src_stall(arb_stall), .req(req_bus)
  );

  shade_pipe #(.OUT_DEPTH(OUT_DEPTH)) u_pipe (
    .clk, .arst_n, .req(req_bus),
    .ram_raddr, .ram_rdata, .pb_full, .pb_we, .pb_data
  );

endmodule

`default_nettype wire
